//--- hw/frame_route_ctrl.sv
// ----------------------------------------------------------
// frame route controller
// accepts connect and disconnect commands and holds the
// current route; tracks frame boundaries on the routed source
// so that a route only changes between frames
// ----------------------------------------------------------

`timescale 1ns/1ps

module frame_route_ctrl (
    input  logic                                      aclk,
    input  logic                                      reset,

    // route command
    input  logic                                      cmd_valid,
    output logic                                      cmd_ready,
    input  stream_route_pkg::route_op_t               cmd_op,
    input  logic [stream_route_pkg::SRC_SEL_BITS-1:0] cmd_src,
    input  logic [stream_route_pkg::SNK_SEL_BITS-1:0] cmd_dst,

    // source handshakes, observed only
    input  logic [stream_route_pkg::SRC_NUM-1:0]      s_tvalid,
    input  logic [stream_route_pkg::SRC_NUM-1:0]      s_tready,
    input  logic [stream_route_pkg::SRC_NUM-1:0]      s_tlast,

    // crossbar select
    output logic                                      route_en,
    output logic [stream_route_pkg::SRC_SEL_BITS-1:0] sel_src,
    output logic [stream_route_pkg::SNK_SEL_BITS-1:0] sel_dst
);

    import stream_route_pkg::*;

    route_state_t state;
    route_state_t state_next;

    logic beat;
    logic frame_start;
    logic frame_end;
    logic cmd_fire;

    // ----------------------------------------------------------
    // handshake decode on the held source
    // ----------------------------------------------------------
    assign beat        = s_tvalid[sel_src] && s_tready[sel_src];
    assign frame_start = beat && !s_tlast[sel_src];
    assign frame_end   = beat && s_tlast[sel_src];

    // a command never lands on the beat that opens a frame,
    // otherwise the rest of that frame would follow the new route
    assign cmd_ready = (state != ROUTE_IN_FRAME) && !frame_start;
    assign cmd_fire  = cmd_valid && cmd_ready;

    assign route_en = (state != ROUTE_OFF);

    // ----------------------------------------------------------
    // next state
    // ----------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            ROUTE_OFF: begin
                if (cmd_fire && cmd_op == ROUTE_CONNECT) begin
                    state_next = ROUTE_OPEN;
                end
            end
            ROUTE_OPEN: begin
                if (cmd_fire) begin
                    state_next = (cmd_op == ROUTE_CONNECT) ? ROUTE_OPEN : ROUTE_OFF;
                end else if (frame_start) begin
                    state_next = ROUTE_IN_FRAME;
                end
            end
            ROUTE_IN_FRAME: begin
                // one-beat frames never get here
                if (frame_end) begin
                    state_next = ROUTE_OPEN;
                end
            end
            default: begin
                state_next = ROUTE_OFF;
            end
        endcase
    end

    // ----------------------------------------------------------
    // state and route registers
    // ----------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset) begin
            state   <= ROUTE_OFF;
            sel_src <= '0;
            sel_dst <= '0;
        end else begin
            state <= state_next;
            // new route takes effect the cycle after acceptance
            if (cmd_fire && cmd_op == ROUTE_CONNECT) begin
                sel_src <= cmd_src;
                sel_dst <= cmd_dst;
            end
        end
    end

endmodule

//--- hw/stream_route_pkg.sv
// ----------------------------------------------------------
// stream route package
// port counts, field widths and enums shared by the
// frame-aware AXI4-Stream router and its testbench
// ----------------------------------------------------------

package stream_route_pkg;

    // ----------------------------------------------------------
    // port counts
    // ----------------------------------------------------------
    localparam int SRC_NUM = 4;
    localparam int SNK_NUM = 2;

    // index widths, sink index sized from the sink count
    localparam int SRC_SEL_BITS = SRC_NUM > 1 ? $clog2(SRC_NUM) : 1;
    localparam int SNK_SEL_BITS = SNK_NUM > 1 ? $clog2(SNK_NUM) : 1;

    // ----------------------------------------------------------
    // stream fields
    // ----------------------------------------------------------
    localparam int DATA_BITS = 16;
    localparam int USER_BITS = 1;

    // ready seen by a source that is not routed
    localparam bit DEFAULT_READY = 1'b0;

    // route command opcodes
    typedef enum logic [0:0] {
        ROUTE_CONNECT    = 1'b0,
        ROUTE_DISCONNECT = 1'b1
    } route_op_t;

    // controller state
    typedef enum logic [1:0] {
        ROUTE_OFF      = 2'd0,
        ROUTE_OPEN     = 2'd1,
        ROUTE_IN_FRAME = 2'd2
    } route_state_t;

endpackage

//--- hw/stream_route_top.sv
// ----------------------------------------------------------
// stream route top
// frame-aware router, four AXI4-Stream sources onto two
// sinks; route controller, crossbar and one skid slice per
// sink
// ----------------------------------------------------------

`timescale 1ns/1ps

module stream_route_top (
    input  logic                                      aclk,
    input  logic                                      reset,

    // sources
    input  logic [stream_route_pkg::SRC_NUM-1:0][stream_route_pkg::DATA_BITS-1:0] s_tdata,
    input  logic [stream_route_pkg::SRC_NUM-1:0][stream_route_pkg::USER_BITS-1:0] s_tuser,
    input  logic [stream_route_pkg::SRC_NUM-1:0]      s_tlast,
    input  logic [stream_route_pkg::SRC_NUM-1:0]      s_tvalid,
    output logic [stream_route_pkg::SRC_NUM-1:0]      s_tready,

    // sinks
    output logic [stream_route_pkg::SNK_NUM-1:0][stream_route_pkg::DATA_BITS-1:0] m_tdata,
    output logic [stream_route_pkg::SNK_NUM-1:0][stream_route_pkg::USER_BITS-1:0] m_tuser,
    output logic [stream_route_pkg::SNK_NUM-1:0]      m_tlast,
    output logic [stream_route_pkg::SNK_NUM-1:0]      m_tvalid,
    input  logic [stream_route_pkg::SNK_NUM-1:0]      m_tready,

    // route command
    input  logic                                      cmd_valid,
    output logic                                      cmd_ready,
    input  stream_route_pkg::route_op_t               cmd_op,
    input  logic [stream_route_pkg::SRC_SEL_BITS-1:0] cmd_src,
    input  logic [stream_route_pkg::SNK_SEL_BITS-1:0] cmd_dst
);

    import stream_route_pkg::*;

    // crossbar select
    logic                    route_en;
    logic [SRC_SEL_BITS-1:0] sel_src;
    logic [SNK_SEL_BITS-1:0] sel_dst;

    // crossbar to slices
    logic [SNK_NUM-1:0][DATA_BITS-1:0] x_tdata;
    logic [SNK_NUM-1:0][USER_BITS-1:0] x_tuser;
    logic [SNK_NUM-1:0]                x_tlast;
    logic [SNK_NUM-1:0]                x_tvalid;
    logic [SNK_NUM-1:0]                x_tready;

    // ----------------------------------------------------------
    // route control
    // ----------------------------------------------------------
    frame_route_ctrl u_ctrl (
        .aclk      (aclk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_src   (cmd_src),
        .cmd_dst   (cmd_dst),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .s_tlast   (s_tlast),
        .route_en  (route_en),
        .sel_src   (sel_src),
        .sel_dst   (sel_dst)
    );

    stream_switch u_switch (
        .route_en (route_en),
        .sel_src  (sel_src),
        .sel_dst  (sel_dst),
        .s_tdata  (s_tdata),
        .s_tuser  (s_tuser),
        .s_tlast  (s_tlast),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .x_tdata  (x_tdata),
        .x_tuser  (x_tuser),
        .x_tlast  (x_tlast),
        .x_tvalid (x_tvalid),
        .x_tready (x_tready)
    );

    // ----------------------------------------------------------
    // one skid slice per sink
    // ----------------------------------------------------------
    for (genvar i = 0; i < SNK_NUM; i++) begin : g_slice
        stream_skid_slice u_slice (
            .aclk       (aclk),
            .reset      (reset),
            .in_tdata   (x_tdata[i]),
            .in_tuser   (x_tuser[i]),
            .in_tlast   (x_tlast[i]),
            .in_tvalid  (x_tvalid[i]),
            .in_tready  (x_tready[i]),
            .out_tdata  (m_tdata[i]),
            .out_tuser  (m_tuser[i]),
            .out_tlast  (m_tlast[i]),
            .out_tvalid (m_tvalid[i]),
            .out_tready (m_tready[i])
        );
    end

endmodule

//--- hw/stream_skid_slice.sv
// ----------------------------------------------------------
// stream skid slice
// two-entry registered buffer for one stream; the input ready
// comes from a flop so the downstream ready path is cut while
// one beat per cycle still flows
// ----------------------------------------------------------

`timescale 1ns/1ps

module stream_skid_slice (
    input  logic                                   aclk,
    input  logic                                   reset,

    input  logic [stream_route_pkg::DATA_BITS-1:0] in_tdata,
    input  logic [stream_route_pkg::USER_BITS-1:0] in_tuser,
    input  logic                                   in_tlast,
    input  logic                                   in_tvalid,
    output logic                                   in_tready,

    output logic [stream_route_pkg::DATA_BITS-1:0] out_tdata,
    output logic [stream_route_pkg::USER_BITS-1:0] out_tuser,
    output logic                                   out_tlast,
    output logic                                   out_tvalid,
    input  logic                                   out_tready
);

    import stream_route_pkg::*;

    // skid entry
    logic [DATA_BITS-1:0] skid_tdata;
    logic [USER_BITS-1:0] skid_tuser;
    logic                 skid_tlast;
    logic                 skid_valid;

    logic in_fire;
    logic out_free;

    // ready drops only once the skid entry holds a beat
    assign in_tready = !skid_valid;
    assign in_fire   = in_tvalid && in_tready;
    // main register may take a new beat this cycle
    assign out_free  = out_tready || !out_tvalid;

    // ----------------------------------------------------------
    // valid flags
    // ----------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset) begin
            out_tvalid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // skid drains first to keep order
            out_tvalid <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    // ----------------------------------------------------------
    // payload
    // ----------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (out_free) begin
            if (skid_valid) begin
                out_tdata <= skid_tdata;
                out_tuser <= skid_tuser;
                out_tlast <= skid_tlast;
            end else if (in_fire) begin
                out_tdata <= in_tdata;
                out_tuser <= in_tuser;
                out_tlast <= in_tlast;
            end
        end else if (in_fire) begin
            skid_tdata <= in_tdata;
            skid_tuser <= in_tuser;
            skid_tlast <= in_tlast;
        end
    end

endmodule

//--- hw/stream_switch.sv
// ----------------------------------------------------------
// stream switch
// combinational crossbar, one selected source drives one
// selected sink; unrouted sources get the default ready and
// unrouted sinks stay invalid with zero payload
// ----------------------------------------------------------

`timescale 1ns/1ps

module stream_switch (
    input  logic                                    route_en,
    input  logic [stream_route_pkg::SRC_SEL_BITS-1:0] sel_src,
    input  logic [stream_route_pkg::SNK_SEL_BITS-1:0] sel_dst,

    // source side
    input  logic [stream_route_pkg::SRC_NUM-1:0][stream_route_pkg::DATA_BITS-1:0] s_tdata,
    input  logic [stream_route_pkg::SRC_NUM-1:0][stream_route_pkg::USER_BITS-1:0] s_tuser,
    input  logic [stream_route_pkg::SRC_NUM-1:0]    s_tlast,
    input  logic [stream_route_pkg::SRC_NUM-1:0]    s_tvalid,
    output logic [stream_route_pkg::SRC_NUM-1:0]    s_tready,

    // sink side, towards the skid slices
    output logic [stream_route_pkg::SNK_NUM-1:0][stream_route_pkg::DATA_BITS-1:0] x_tdata,
    output logic [stream_route_pkg::SNK_NUM-1:0][stream_route_pkg::USER_BITS-1:0] x_tuser,
    output logic [stream_route_pkg::SNK_NUM-1:0]    x_tlast,
    output logic [stream_route_pkg::SNK_NUM-1:0]    x_tvalid,
    input  logic [stream_route_pkg::SNK_NUM-1:0]    x_tready
);

    import stream_route_pkg::*;

    // ----------------------------------------------------------
    // forward path
    // ----------------------------------------------------------
    always_comb begin
        // idle sinks carry nothing
        x_tdata  = '0;
        x_tuser  = '0;
        x_tlast  = '0;
        x_tvalid = '0;

        if (route_en) begin
            x_tdata[sel_dst]  = s_tdata[sel_src];
            x_tuser[sel_dst]  = s_tuser[sel_src];
            x_tlast[sel_dst]  = s_tlast[sel_src];
            x_tvalid[sel_dst] = s_tvalid[sel_src];
        end
    end

    // ----------------------------------------------------------
    // ready path
    // ----------------------------------------------------------
    always_comb begin
        s_tready = {SRC_NUM{DEFAULT_READY}};

        // only the routed source sees the sink's ready
        if (route_en) begin
            s_tready[sel_src] = x_tready[sel_dst];
        end
    end

endmodule

//--- list.f
hw/stream_route_pkg.sv
hw/stream_switch.sv
hw/frame_route_ctrl.sv
hw/stream_skid_slice.sv
hw/stream_route_top.sv
tests/stream_route_chk.sv
tests/stream_route_tb.sv

//--- run.sh
#!/bin/sh
# build and run the stream router testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module stream_route_tb -o sim_route > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_route > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

//--- tests/route_cases.txt
# name op src dst frame_len backpressure
# reroute issues the connect mid-frame on the route already held
conn_s0_m0     connect    0 0 4  0
conn_s1_m1     connect    1 1 6  0
conn_s2_m0     connect    2 0 1  0
conn_s3_m1     connect    3 1 8  0
hold_s1_m0     reroute    1 0 5  0
bp_s2_m1       connect    2 1 12 1
bp_s0_m0       connect    0 0 16 1
hold_bp_s3_m1  reroute    3 1 6  1
disc_s3        disconnect 3 0 0  0
conn_s1_m0     connect    1 0 3  0
bp_s2_m0       connect    2 0 9  1
disc_s2        disconnect 2 0 0  1

//--- tests/stream_route_chk.sv
// ----------------------------------------------------------
// stream route checker
// concurrent assertions on the router handshakes, bound
// into the top level
// ----------------------------------------------------------

`timescale 1ns/1ps

module stream_route_chk (
    input logic                                                                aclk,
    input logic                                                                reset,
    input logic [stream_route_pkg::SRC_NUM-1:0]                                s_tvalid,
    input logic [stream_route_pkg::SRC_NUM-1:0]                                s_tready,
    input logic [stream_route_pkg::SRC_NUM-1:0]                                s_tlast,
    input logic [stream_route_pkg::SNK_NUM-1:0][stream_route_pkg::DATA_BITS-1:0] m_tdata,
    input logic [stream_route_pkg::SNK_NUM-1:0][stream_route_pkg::USER_BITS-1:0] m_tuser,
    input logic [stream_route_pkg::SNK_NUM-1:0]                                m_tlast,
    input logic [stream_route_pkg::SNK_NUM-1:0]                                m_tvalid,
    input logic [stream_route_pkg::SNK_NUM-1:0]                                m_tready,
    input logic                                                                cmd_valid,
    input logic                                                                cmd_ready,
    input stream_route_pkg::route_op_t                                         cmd_op,
    input logic [stream_route_pkg::SRC_SEL_BITS-1:0]                           cmd_src,
    input logic [stream_route_pkg::SNK_SEL_BITS-1:0]                           cmd_dst
);

    import stream_route_pkg::*;

    logic in_frame;

    // frame tracking from the source handshakes alone
    always_ff @(posedge aclk) begin
        if (reset) begin
            in_frame <= 1'b0;
        end else if (|(s_tvalid & s_tready)) begin
            in_frame <= !(|(s_tvalid & s_tready & s_tlast));
        end
    end

    for (genvar i = 0; i < SNK_NUM; i++) begin : g_sink
        assert property (@(posedge aclk) disable iff (reset)
            m_tvalid[i] && !m_tready[i] |=>
                m_tvalid[i] && $stable({m_tdata[i], m_tuser[i], m_tlast[i]}))
            else $error("sink %0d dropped or changed a stalled beat", i);
    end

    assert property (@(posedge aclk) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable({cmd_op, cmd_src, cmd_dst}))
        else $error("route command dropped or changed while stalled");

    assert property (@(posedge aclk) disable iff (reset) in_frame |-> !cmd_ready)
        else $error("cmd_ready high inside a frame");

    assert property (@(posedge aclk) reset |=> m_tvalid == '0)
        else $error("sink valid out of reset");

endmodule

bind stream_route_top stream_route_chk u_chk (.*);

//--- tests/stream_route_tb.sv
// ----------------------------------------------------------
// stream route testbench
// reads route cases from a file, issues commands, sends one
// frame per case and checks what comes out of the sinks
// ----------------------------------------------------------

`timescale 1ns/1ps

module stream_route_tb;

    import stream_route_pkg::*;

    localparam int TIMEOUT = 500;
    localparam int OFF_WINDOW = 20;

    logic                              aclk;
    logic                              reset;
    logic [SRC_NUM-1:0][DATA_BITS-1:0] s_tdata;
    logic [SRC_NUM-1:0][USER_BITS-1:0] s_tuser;
    logic [SRC_NUM-1:0]                s_tlast;
    logic [SRC_NUM-1:0]                s_tvalid;
    logic [SRC_NUM-1:0]                s_tready;
    logic [SNK_NUM-1:0][DATA_BITS-1:0] m_tdata;
    logic [SNK_NUM-1:0][USER_BITS-1:0] m_tuser;
    logic [SNK_NUM-1:0]                m_tlast;
    logic [SNK_NUM-1:0]                m_tvalid;
    logic [SNK_NUM-1:0]                m_tready;
    logic                              cmd_valid;
    logic                              cmd_ready;
    route_op_t                         cmd_op;
    logic [SRC_SEL_BITS-1:0]           cmd_src;
    logic [SNK_SEL_BITS-1:0]           cmd_dst;

    int     errors;
    int     checks;
    int     case_idx;
    bit     hung;
    bit     bp_mode;
    bit     routed;
    int     cur_src;
    int     cur_dst;
    int     beats_done;
    time    last_time;
    time    cmd_time;
    integer seed = 32'he47323eb;

    stream_route_top dut0 (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // sink ready, random only in back-pressure cases
    initial begin
        m_tready = '1;
        forever begin
            @(negedge aclk);
            for (int i = 0; i < SNK_NUM; i++) begin
                m_tready[i] = bp_mode ? 1'($random(seed)) : 1'b1;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic note_wait(inout int waited, input string what);
        waited++;
        if (waited > TIMEOUT) begin
            $display("timeout, %s", what);
            errors++;
            hung = 1'b1;
        end
    endtask

    // ----------------------------------------------------------
    // stray sink valids and leaks from unrouted sources
    // ----------------------------------------------------------
    always @(posedge aclk) begin
        if (!reset) begin
            for (int i = 0; i < SNK_NUM; i++) begin
                if (m_tvalid[i] && !(routed && i == cur_dst)) begin
                    check($sformatf("sink %0d unrouted valid", i), 0, 1);
                end
            end
            for (int i = 0; i < SRC_NUM; i++) begin
                if (s_tvalid[i] && s_tready[i] && !(routed && i == cur_src)) begin
                    check($sformatf("source %0d isolation", i), 0, 1);
                end
            end
        end
    end

    task automatic send_cmd(input route_op_t op, input int src, input int dst);
        int waited;
        bit done;
        waited = 0;
        done = 1'b0;
        @(negedge aclk);
        cmd_valid = 1'b1;
        cmd_op = op;
        cmd_src = SRC_SEL_BITS'(src);
        cmd_dst = SNK_SEL_BITS'(dst);
        while (!done && !hung) begin
            @(posedge aclk);
            if (cmd_ready) begin
                done = 1'b1;
                cmd_time = $time;
            end else begin
                note_wait(waited, "route command never accepted");
            end
        end
        @(negedge aclk);
        cmd_valid = 1'b0;
    endtask

    task automatic send_frame(input int src, input int first_k, input int count);
        int waited;
        bit taken;
        for (int k = first_k; k < first_k + count && !hung; k++) begin
            @(negedge aclk);
            // every other source offers a beat that must stay blocked
            for (int i = 0; i < SRC_NUM; i++) begin
                s_tvalid[i] = 1'b1;
                s_tdata[i] = DATA_BITS'(16'hf000 + i);
                s_tlast[i] = 1'b1;
            end
            s_tdata[src] = DATA_BITS'(case_idx * 256 + k);
            s_tuser[src] = USER_BITS'(k == first_k);
            s_tlast[src] = (k == first_k + count - 1);
            taken = 1'b0;
            waited = 0;
            while (!taken && !hung) begin
                @(posedge aclk);
                if (s_tready[src]) begin
                    taken = 1'b1;
                    last_time = $time;
                    beats_done++;
                end else begin
                    note_wait(waited, $sformatf("source %0d beat %0d never taken", src, k));
                end
            end
        end
        @(negedge aclk);
        s_tvalid = '0;
        s_tuser = '0;
        s_tlast = '0;
    endtask

    task automatic collect_frame(input string name, input int dst, input int first_k,
                                 input int count);
        int k;
        int waited;
        k = first_k;
        waited = 0;
        while (k < first_k + count && !hung) begin
            @(posedge aclk);
            if (m_tvalid[dst] && m_tready[dst]) begin
                check({name, " tdata"}, case_idx * 256 + k, m_tdata[dst]);
                check({name, " tuser"}, k == first_k, m_tuser[dst]);
                check({name, " tlast"}, k == first_k + count - 1, m_tlast[dst]);
                k++;
                waited = 0;
            end else begin
                note_wait(waited, $sformatf("sink %0d stalled before beat %0d", dst, k));
            end
        end
    endtask

    task automatic run_frame(input string name, input int src, input int dst,
                             input int first_k, input int count);
        fork
            send_frame(src, first_k, count);
            collect_frame(name, dst, first_k, count);
        join
    endtask

    task automatic check_idle(input string when);
        check({when, " m_tvalid"}, 0, m_tvalid);
        check({when, " s_tready"}, 0, s_tready);
        check({when, " cmd_ready"}, 1, cmd_ready);
    endtask

    // ----------------------------------------------------------
    // one case from the file
    // ----------------------------------------------------------
    task automatic run_case(input string name, input logic [127:0] op, input int src,
                            input int dst, input int len);
        if (op == "connect") begin
            send_cmd(ROUTE_CONNECT, src, dst);
            routed = 1'b1;
            cur_src = src;
            cur_dst = dst;
            run_frame(name, src, dst, 0, len);
        end else if (op == "disconnect") begin
            send_cmd(ROUTE_DISCONNECT, src, dst);
            routed = 1'b0;
            @(negedge aclk);
            s_tvalid[src] = 1'b1;
            s_tdata[src] = DATA_BITS'(case_idx * 256);
            repeat (OFF_WINDOW) begin
                @(posedge aclk);
                check({name, " s_tready"}, 0, s_tready[src]);
            end
            @(negedge aclk);
            s_tvalid = '0;
        end else if (op == "reroute" && routed) begin
            // old frame in flight while the new connect waits
            beats_done = 0;
            fork
                run_frame(name, cur_src, cur_dst, 0, len);
                begin
                    int waited;
                    waited = 0;
                    while (beats_done == 0 && !hung) begin
                        @(negedge aclk);
                        note_wait(waited, "held frame never started");
                    end
                    send_cmd(ROUTE_CONNECT, src, dst);
                end
            join
            // old sink may still be draining at this edge
            @(negedge aclk);
            check({name, " hold"}, 1, cmd_time > last_time);
            cur_src = src;
            cur_dst = dst;
            run_frame(name, src, dst, len, len);
        end else begin
            $display("case %s cannot run, unknown opcode or no route held", name);
            errors++;
        end
    endtask

    initial begin
        int fd;
        int n;
        int src;
        int dst;
        int len;
        int bp;
        string line;
        logic [255:0] name_w;
        logic [127:0] op_w;
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = ROUTE_CONNECT;
        cmd_src = '0;
        cmd_dst = '0;
        s_tdata = '0;
        s_tuser = '0;
        s_tlast = '0;
        s_tvalid = '0;
        repeat (5) @(negedge aclk);
        check_idle("in reset");
        repeat (5) @(negedge aclk);
        reset = 1'b0;
        @(negedge aclk);
        check_idle("after reset");
        fd = $fopen("tests/route_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file tests/route_cases.txt");
            errors++;
        end else begin
            while (!hung && $fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %s %d %d %d %d", name_w, op_w, src, dst, len, bp);
                if (line.substr(0, 0) != "#" && n == 6) begin
                    bp_mode = (bp != 0);
                    run_case($sformatf("%0s", name_w), op_w, src, dst, len);
                    case_idx++;
                end
            end
            $fclose(fd);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
